// File: design/inputMux_defs.svh
// Widths, CSR region codes and CSR bit positions for the input mux, included by package and RTL
`ifndef INPUTMUX_DEFS_SVH
`define INPUTMUX_DEFS_SVH

// ==================================================
// Widths
// ==================================================
`define XLEN            32 // Core data word
`define IO_WIDTH        16 // External IO port, zero-extended to XLEN (1..32)

// ==================================================
// CSR region field in the address
// ==================================================
`define CSR_REGION_MSB  29
`define CSR_REGION_LSB  27
`define REGION_MIP      5  // Machine interrupt pending
`define REGION_MIE      6  // Machine interrupt enable
`define REGION_MSTATUS  7  // Machine status
// Region codes 0..4 read the IO port

// Bit positions shared by MIP and MIE
`define BIT_SW          3
`define BIT_TIMER       7
`define BIT_EXT         11
`define BIT_MPP         12 // MSTATUS only, reads as one
`define BIT_TIMEINC     16
`define BIT_INSTRET     17

// MSTATUS interrupt enable bits
`define BIT_MIE         3
`define BIT_MPIE        7

`endif

// File: design/inputMuxPkg.sv
// Shared types of the input mux, referenced as inputMuxPkg::name from the RTL and testbench
`include "inputMux_defs.svh"

package inputMuxPkg;

    // ==================================================
    // Bus address
    // ==================================================

    // Address split around the CSR region field
    typedef struct packed {
        logic [`XLEN-1:`CSR_REGION_MSB+1]           top;    // Unused by the decode
        logic [`CSR_REGION_MSB:`CSR_REGION_LSB]     region; // Selects MIP/MIE/MSTATUS or IO
        logic [`CSR_REGION_LSB-1:0]                 offset; // Word offset in region
    } busAddrFields;

    // Same word seen two ways
    // raw view feeds the right shift in the output stage,
    // fields view feeds the CSR region decode
    typedef union packed {
        logic [`XLEN-1:0] raw;      // Whole address word
        busAddrFields     fields;   // Decoded view
    } busAddr;

    // ==================================================
    // Interrupt state from the CSR block
    // ==================================================
    typedef struct packed {
        // MSTATUS
        logic mie;          // Global machine interrupt enable
        logic mpie;         // Previous value of mie
        // MIE enables
        logic extEn;        // External
        logic instretEn;    // Retired instruction
        logic swEn;         // Software
        logic timerEn;      // Timer compare
        logic timeIncEn;    // Time increment
        // MIP pending
        logic instretPend;
        logic swPend;
        logic timerPend;
        logic timeIncPend;
        logic extPend;
        logic sparePend;    // Reserved, driven low at the top level
    } irqBits;

endpackage

// File: design/csrReadDecode.sv
// CSR region decode: builds the MIP, MIE and MSTATUS read words and acknowledges CSR strobes
`timescale 1ns/1ps
`include "inputMux_defs.svh"

module csrReadDecode (
    input  inputMuxPkg::busAddr   adr,     // Address from core
    input  logic                  stb,     // Strobe from core
    input  logic [`IO_WIDTH-1:0]  ioData,  // External IO port
    input  inputMuxPkg::irqBits   irq,     // Interrupt state
    output logic [`XLEN-1:0]      ioWord,  // IO or CSR word to capture stage
    output logic                  sysAck   // Same-cycle acknowledge for CSR reads
);

    logic [`XLEN-1:0] ioExt;       // IO port zero-extended
    logic [`XLEN-1:0] mipWord;
    logic [`XLEN-1:0] mieWord;
    logic [`XLEN-1:0] mstatusWord;
    logic             isCsr;       // Region hits a system register

    // ==================================================
    // Word composition
    // ==================================================

    // Zero-extend the IO port, also correct when IO_WIDTH equals XLEN
    always_comb begin
        ioExt = '0;
        ioExt[`IO_WIDTH-1:0] = ioData;
    end

    // Pending bits
    always_comb begin
        mipWord = '0;
        mipWord[`BIT_SW]      = irq.swPend;
        mipWord[`BIT_TIMER]   = irq.timerPend;
        mipWord[`BIT_EXT]     = irq.extPend;
        mipWord[`BIT_TIMEINC] = irq.timeIncPend;
        mipWord[`BIT_INSTRET] = irq.instretPend;
    end

    // Enable bits, same positions as MIP
    always_comb begin
        mieWord = '0;
        mieWord[`BIT_SW]      = irq.swEn;
        mieWord[`BIT_TIMER]   = irq.timerEn;
        mieWord[`BIT_EXT]     = irq.extEn;
        mieWord[`BIT_TIMEINC] = irq.timeIncEn;
        mieWord[`BIT_INSTRET] = irq.instretEn;
    end

    // Machine mode only, so MPP reads back as one
    always_comb begin
        mstatusWord = '0;
        mstatusWord[`BIT_MIE]  = irq.mie;
        mstatusWord[`BIT_MPIE] = irq.mpie;
        mstatusWord[`BIT_EXT]  = 1'b1;     // Constant one
        mstatusWord[`BIT_MPP]  = 1'b1;     // Constant one
    end

    // ==================================================
    // Region select
    // ==================================================
    always_comb begin
        isCsr  = 1'b1;
        ioWord = ioExt;
        case (adr.fields.region)
            `REGION_MIP:     ioWord = mipWord;
            `REGION_MIE:     ioWord = mieWord;
            `REGION_MSTATUS: ioWord = mstatusWord;
            default: begin
                isCsr  = 1'b0;             // Plain IO read
                ioWord = ioExt;
            end
        endcase
    end

    // No wait states on system registers
    assign sysAck = stb & isCsr;

endmodule

// File: design/readCapture.sv
// Read capture stage: picks IO/CSR, MUL/DIV or SRAM data and registers it while the core runs
`timescale 1ns/1ps
`include "inputMux_defs.svh"

module readCapture (
    input  logic             clk,
    input  logic             reset,
    input  logic             coreRunning,   // Capture enable
    input  logic             stb,           // IO/CSR access in progress
    input  logic             clrM,          // Together with ceM flags a MUL/DIV read
    input  logic             ceM,
    input  logic [`XLEN-1:0] ioWord,        // From CSR decode
    input  logic [`XLEN-1:0] sramData,      // SRAM read word
    input  logic [`XLEN-1:0] mulDivResult,  // MUL/DIV result register
    output logic [`XLEN-1:0] capWord        // Captured read data
);

    logic             readM;    // MUL/DIV result requested
    logic [`XLEN-1:0] selWord;  // Word to capture

    // ==================================================
    // Source select
    // ==================================================

    assign readM = clrM & ceM;

    // MUL/DIV wins over a pending strobe
    // IO data may be nonzero while idle, so a real mux is kept here
    always_comb begin
        if (readM) begin
            selWord = mulDivResult;
        end else if (stb) begin
            selWord = ioWord;      // IO port or system register
        end else begin
            selWord = sramData;    // Default source
        end
    end

    // ==================================================
    // Capture register
    // ==================================================

    // Holds while the core is stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            capWord <= '0;
        end else if (coreRunning) begin
            capWord <= selWord;
        end
    end

endmodule

// File: design/operandBlend.sv
// Output stage: blends block-RAM data with the captured word and the right-shifted address
`timescale 1ns/1ps
`include "inputMux_defs.svh"

module operandBlend (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 coreRunning,
    input  logic                 sa00,         // Main select from microcode, pipelined
    input  logic                 qAck,         // Qualified bus acknowledge
    input  logic                 sramAck,      // SRAM acknowledge
    input  logic [`XLEN-1:0]     ebrData,      // Block-RAM word, also the blend mask
    input  logic [`XLEN-1:0]     capWord,      // Captured read data
    input  inputMuxPkg::busAddr  adr,          // Address for the shift path
    input  logic                 sraMsb,       // Bit shifted in at the top
    output logic [`XLEN-1:0]     di            // Data into the core
);

    logic             passEbr;  // Block-RAM word goes straight through
    logic [`XLEN-1:0] shAdr;    // Address shifted right by one

    // ==================================================
    // Pass-through flag
    // ==================================================

    // Set only on an idle cycle of a running core
    always_ff @(posedge clk) begin
        if (reset) begin
            passEbr <= 1'b0;
        end else begin
            passEbr <= coreRunning & ~(sa00 | qAck | sramAck);
        end
    end

    // ==================================================
    // Blend
    // ==================================================

    assign shAdr = {sraMsb, adr.raw[`XLEN-1:1]};  // Arithmetic or logic shift, caller decides

    // Per bit: ebrData one picks capWord, zero picks shifted address
    always_comb begin
        if (passEbr) begin
            di = ebrData;
        end else begin
            di = (ebrData & capWord) | (~ebrData & shAdr);
        end
    end

endmodule

// File: design/inputMux.sv
// Input mux top level: CSR decode, read capture and output blend for the core's read path
`timescale 1ns/1ps
`include "inputMux_defs.svh"

module inputMux (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 coreRunning,   // Registers update only while running
    input  logic [`XLEN-1:0]     ebrData,       // Internal block-RAM word
    input  logic [`IO_WIDTH-1:0] ioData,        // External IO port
    input  logic [`XLEN-1:0]     sramData,      // SRAM read word
    input  inputMuxPkg::busAddr  adr,           // Bus address from core
    input  logic                 sraMsb,        // Top bit for the shifted address
    input  logic                 sa00,          // Main select, pipelined
    input  logic                 stb,           // Strobe from core
    input  logic                 sramAck,       // SRAM acknowledge
    input  logic                 qAck,          // Qualified acknowledge
    input  inputMuxPkg::irqBits  irq,           // Interrupt state for CSR reads
    input  logic [`XLEN-1:0]     mulDivResult,  // MUL/DIV result register
    input  logic                 clrM,          // MUL/DIV read qualifiers
    input  logic                 ceM,
    output logic                 sysAck,        // CSR acknowledge
    output logic [`XLEN-1:0]     di             // Data into the core
);

    inputMuxPkg::irqBits irqTied;   // Interrupt bits with the spare forced low
    logic [`XLEN-1:0]    ioWord;    // Decode to capture
    logic [`XLEN-1:0]    capWord;   // Capture to blend

    // Spare pending bit has no CSR position yet
    always_comb begin
        irqTied           = irq;
        irqTied.sparePend = 1'b0;
    end

    // ==================================================
    // Stages
    // ==================================================

    // IO port and system registers
    csrReadDecode csrReadDecode_i (
        .adr    (adr),
        .stb    (stb),
        .ioData (ioData),
        .irq    (irqTied),
        .ioWord (ioWord),
        .sysAck (sysAck)
    );

    // Source select and capture register
    readCapture readCapture_i (
        .clk          (clk),
        .reset        (reset),
        .coreRunning  (coreRunning),
        .stb          (stb),
        .clrM         (clrM),
        .ceM          (ceM),
        .ioWord       (ioWord),
        .sramData     (sramData),
        .mulDivResult (mulDivResult),
        .capWord      (capWord)
    );

    // Final blend toward the core
    operandBlend operandBlend_i (
        .clk         (clk),
        .reset       (reset),
        .coreRunning (coreRunning),
        .sa00        (sa00),
        .qAck        (qAck),
        .sramAck     (sramAck),
        .ebrData     (ebrData),
        .capWord     (capWord),
        .adr         (adr),
        .sraMsb      (sraMsb),
        .di          (di)
    );

endmodule

// File: tests/inputMuxTb.sv
// Table-driven testbench for the input mux that runs as the simulation top over the file list
`timescale 1ns/1ps
`include "inputMux_defs.svh"

module inputMuxTb;

    // ==================================================
    // Types and constants
    // ==================================================
    typedef logic [`XLEN-1:0] dataWord;

    // One stimulus row with its expected acknowledge
    typedef struct packed {
        logic                 stb;
        inputMuxPkg::busAddr  adr;
        logic [`IO_WIDTH-1:0] ioData;
        dataWord              sramData;
        dataWord              mulDivResult;
        logic                 clrM;
        logic                 ceM;
        inputMuxPkg::irqBits  irq;
        dataWord              ebrData;
        logic                 sa00;
        logic                 qAck;
        logic                 sramAck;
        logic                 coreRunning;
        logic                 sraMsb;
        logic                 expAck;       // Expected sysAck
    } stimRow;

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 40;      // Clock cycles allowed for reset release
    localparam int FILLER_ROWS   = 24;      // Random rows after the directed ones

    // ==================================================
    // DUT signals
    // ==================================================
    logic                 clk = 1'b0;
    logic                 reset = 1'b1;     // Held from time zero
    logic                 coreRunning;
    dataWord              ebrData;
    logic [`IO_WIDTH-1:0] ioData;
    dataWord              sramData;
    inputMuxPkg::busAddr  adr;
    logic                 sraMsb;
    logic                 sa00;
    logic                 stb;
    logic                 sramAck;
    logic                 qAck;
    inputMuxPkg::irqBits  irq;
    dataWord              mulDivResult;
    logic                 clrM;
    logic                 ceM;
    logic                 sysAck;
    dataWord              di;

    // Reference model state
    dataWord     capRef = '0;               // Captured word
    logic        passRef = 1'b0;            // Block-RAM pass-through
    logic [31:0] lcgState = 32'd39968;
    stimRow      rows[$];

    inputMux dut_i (
        .clk          (clk),
        .reset        (reset),
        .coreRunning  (coreRunning),
        .ebrData      (ebrData),
        .ioData       (ioData),
        .sramData     (sramData),
        .adr          (adr),
        .sraMsb       (sraMsb),
        .sa00         (sa00),
        .stb          (stb),
        .sramAck      (sramAck),
        .qAck         (qAck),
        .irq          (irq),
        .mulDivResult (mulDivResult),
        .clrM         (clrM),
        .ceM          (ceM),
        .sysAck       (sysAck),
        .di           (di)
    );

    always #20 clk = ~clk;                  // 40 ns period

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Full-period 32-bit LCG
    function automatic dataWord nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // CSR regions acknowledge on the same cycle
    function automatic logic ackRule(input stimRow r);
        logic [2:0] region;
        region = r.adr.fields.region;
        return r.stb && (region == 3'(`REGION_MIP) || region == 3'(`REGION_MIE)
                         || region == 3'(`REGION_MSTATUS));
    endfunction

    function automatic stimRow randomRow();
        stimRow  r;
        dataWord bits;
        r.adr.raw      = nextRandom();
        r.sramData     = nextRandom();
        r.mulDivResult = nextRandom();
        r.ebrData      = nextRandom();
        bits           = nextRandom();
        r.ioData       = bits[31:32-`IO_WIDTH];  // Upper LCG bits are the better ones
        bits           = nextRandom();
        r.irq          = bits[31:19];
        bits           = nextRandom();
        r.stb          = bits[31];
        r.clrM         = bits[30];
        r.ceM          = bits[29];
        r.sa00         = bits[28];
        r.qAck         = bits[27];
        r.sramAck      = bits[26];
        r.coreRunning  = bits[25];
        r.sraMsb       = bits[24];
        r.expAck       = ackRule(r);
        return r;
    endfunction

    // Running core with random data and sa00 high so di shows the captured word
    function automatic stimRow quietRow();
        stimRow r;
        r             = randomRow();
        r.stb         = 1'b0;
        r.clrM        = 1'b0;
        r.ceM         = 1'b0;
        r.sa00        = 1'b1;
        r.qAck        = 1'b0;
        r.sramAck     = 1'b0;
        r.coreRunning = 1'b1;
        r.ebrData     = '1;
        r.expAck      = 1'b0;
        return r;
    endfunction

    task automatic buildTable();
        stimRow r;
        // After reset the captured word is zero
        r             = quietRow();
        r.coreRunning = 1'b0;
        r.ebrData     = 32'h0F0F_F0F0;
        rows.push_back(r);
        // Strobed reads of every region
        for (int region = 0; region < 8; region++) begin
            r                  = quietRow();
            r.stb              = 1'b1;
            r.adr.fields.region = 3'(region);
            r.expAck           = (region >= `REGION_MIP);
            rows.push_back(r);
        end
        rows.push_back(quietRow());         // SRAM when idle
        r        = quietRow();
        r.stb    = 1'b1;                    // MUL/DIV beats a CSR strobe
        r.clrM   = 1'b1;
        r.ceM    = 1'b1;
        r.adr.fields.region = 3'(`REGION_MIE);
        r.expAck = 1'b1;
        rows.push_back(r);
        r      = quietRow();
        r.clrM = 1'b1;                      // clrM alone is no MUL/DIV read
        rows.push_back(r);
        // Shift path with both fill bits
        r         = quietRow();
        r.ebrData = '0;
        r.sraMsb  = 1'b1;
        rows.push_back(r);
        r         = quietRow();
        r.ebrData = '0;
        r.sraMsb  = 1'b0;
        rows.push_back(r);
        r         = quietRow();
        r.ebrData = 32'hA5A5_5A5A;          // Per-bit blend
        rows.push_back(r);
        r      = quietRow();
        r.sa00 = 1'b0;                      // Idle cycle gives pass-through
        rows.push_back(r);
        r      = quietRow();
        r.sa00 = 1'b0;
        r.qAck = 1'b1;
        rows.push_back(r);
        r         = quietRow();
        r.sa00    = 1'b0;
        r.sramAck = 1'b1;
        rows.push_back(r);
        // Capture holds while the core is stopped
        r             = quietRow();
        r.coreRunning = 1'b0;
        r.ebrData     = 32'hFFFF_0000;
        rows.push_back(r);
        r             = quietRow();
        r.coreRunning = 1'b0;
        r.stb         = 1'b1;
        r.adr.fields.region = 3'(`REGION_MIP);
        r.expAck      = 1'b1;
        rows.push_back(r);
        for (int n = 0; n < FILLER_ROWS; n++) begin
            rows.push_back(randomRow());
        end
    endtask

    task automatic applyRow(input stimRow r);
        stb          = r.stb;
        adr          = r.adr;
        ioData       = r.ioData;
        sramData     = r.sramData;
        mulDivResult = r.mulDivResult;
        clrM         = r.clrM;
        ceM          = r.ceM;
        irq          = r.irq;
        ebrData      = r.ebrData;
        sa00         = r.sa00;
        qAck         = r.qAck;
        sramAck      = r.sramAck;
        coreRunning  = r.coreRunning;
        sraMsb       = r.sraMsb;
    endtask

    // ==================================================
    // Reference model
    // ==================================================

    // CSR words from the bit map and zero-extended IO elsewhere
    function automatic dataWord csrWord(input stimRow r);
        dataWord w;
        if (r.adr.fields.region == 3'(`REGION_MIP)) begin
            w = (dataWord'(r.irq.swPend) << `BIT_SW) | (dataWord'(r.irq.timerPend) << `BIT_TIMER)
              | (dataWord'(r.irq.extPend) << `BIT_EXT)
              | (dataWord'(r.irq.timeIncPend) << `BIT_TIMEINC)
              | (dataWord'(r.irq.instretPend) << `BIT_INSTRET);
        end else if (r.adr.fields.region == 3'(`REGION_MIE)) begin
            w = (dataWord'(r.irq.swEn) << `BIT_SW) | (dataWord'(r.irq.timerEn) << `BIT_TIMER)
              | (dataWord'(r.irq.extEn) << `BIT_EXT)
              | (dataWord'(r.irq.timeIncEn) << `BIT_TIMEINC)
              | (dataWord'(r.irq.instretEn) << `BIT_INSTRET);
        end else if (r.adr.fields.region == 3'(`REGION_MSTATUS)) begin
            w = (dataWord'(r.irq.mie) << `BIT_MIE) | (dataWord'(r.irq.mpie) << `BIT_MPIE)
              | (dataWord'(1) << `BIT_EXT) | (dataWord'(1) << `BIT_MPP);
        end else begin
            w = dataWord'(r.ioData);
        end
        return w;
    endfunction

    // Register updates at the edge the row was held through
    function automatic void advanceModel(input stimRow r);
        dataWord src;
        if (r.clrM && r.ceM) src = r.mulDivResult;
        else if (r.stb) src = csrWord(r);
        else src = r.sramData;
        if (r.coreRunning) capRef = src;
        passRef = r.coreRunning && !(r.sa00 || r.qAck || r.sramAck);
    endfunction

    function automatic dataWord expectedDi(input stimRow r);
        dataWord shifted;
        dataWord w;
        shifted = {r.sraMsb, r.adr.raw[`XLEN-1:1]};
        for (int b = 0; b < `XLEN; b++) begin
            w[b] = r.ebrData[b] ? capRef[b] : shifted[b];  // Mask bit picks the source
        end
        return passRef ? r.ebrData : w;
    endfunction

    // ==================================================
    // Checks and waits
    // ==================================================
    task automatic checkEq(input dataWord actual, input dataWord expected, input string what);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic awaitResetRelease();
        int waited;
        waited = 0;
        while (reset) begin
            @(negedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                $display("Timeout: reset still high after %0d cycles", RESET_TIMEOUT);
                $display("Regression failed");
                $fatal(1, "Reset wait timed out");
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        stb          = 1'b0;
        adr          = '0;
        ioData       = '0;
        sramData     = '0;
        mulDivResult = '0;
        clrM         = 1'b0;
        ceM          = 1'b0;
        irq          = '0;
        ebrData      = '0;
        sa00         = 1'b0;
        qAck         = 1'b0;
        sramAck      = 1'b0;
        coreRunning  = 1'b0;                // Registers stay cleared until the first row
        sraMsb       = 1'b0;
        buildTable();
        awaitResetRelease();
        @(posedge clk);
        #1;
        for (int i = 0; i < rows.size(); i++) begin
            applyRow(rows[i]);              // 1 ns after the edge
            @(negedge clk);
            checkEq(dataWord'(sysAck), dataWord'(rows[i].expAck),
                    $sformatf("row %0d sysAck", i));
            @(posedge clk);
            advanceModel(rows[i]);
            #1;                             // Inputs still held from the row
            checkEq(di, expectedDi(rows[i]), $sformatf("row %0d di", i));
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: inputMux.f
+incdir+design
design/inputMuxPkg.sv
design/csrReadDecode.sv
design/readCapture.sv
design/operandBlend.sv
design/inputMux.sv
tests/inputMuxTb.sv

// File: Makefile
# Verilator flow for the input mux: lint the RTL, build and run the testbench, clean up

TB_TOP  = inputMuxTb
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: lint sim

# RTL top level only
lint:
	verilator --lint-only --timing --top-module inputMux -f inputMux.f

# Output goes to the terminal and is searched for the pass line
sim:
	verilator --binary --timing --top-module $(TB_TOP) -f inputMux.f \
		--Mdir $(OBJ_DIR) -o simv
	./$(OBJ_DIR)/simv | tee /dev/stderr | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
